// ==== logic/sram_pkg.sv ====
// Shared bus widths, address array and request types for the SRAM target
// Imported by the bus-side modules, the memory wrapper and the testbench
`default_nettype none

package sram_pkg;

   localparam int CFG_SYSBUS_DATA_BITS = 64;
   localparam int CFG_SYSBUS_DATA_BYTES = CFG_SYSBUS_DATA_BITS / 8;   // Strobe width and lane count
   localparam int CFG_LOG2_SYSBUS_DATA_BYTES = 3;                    // Byte offset bits in an address
   localparam int CFG_ALIGN_BYTES = 4;                               // Bytes covered per address entry
   localparam int CFG_WORDS_ALIGNED = CFG_SYSBUS_DATA_BYTES / CFG_ALIGN_BYTES;
   localparam int CFG_SYSBUS_ADDR_BITS = 32;

   // One address per alignment unit of the data bus
   typedef logic [CFG_SYSBUS_ADDR_BITS-1:0] global_addr_array_type [0:CFG_WORDS_ALIGNED-1];

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } req_op_type;

   typedef struct packed {
      req_op_type                        op;
      logic [CFG_SYSBUS_ADDR_BITS-1:0]   addr;    // Byte address
      logic [CFG_SYSBUS_DATA_BYTES-1:0]  wstrb;   // Ignored on reads
      logic [CFG_SYSBUS_DATA_BITS-1:0]   wdata;
   } sram_req_type;

endpackage

`default_nettype wire

// ==== logic/sram_port_if.sv ====
// Memory port between the bus target and the byte-lane SRAM wrapper
// The target drives the access, the memory returns rdata one cycle later
`timescale 1ns/100ps
`default_nettype none

interface sram_port_if (
   input logic clk
);
   import sram_pkg::*;

   global_addr_array_type             raddr;
   global_addr_array_type             waddr;
   logic                              we;
   logic [CFG_SYSBUS_DATA_BYTES-1:0]  wstrb;
   logic [CFG_SYSBUS_DATA_BITS-1:0]   wdata;
   logic [CFG_SYSBUS_DATA_BITS-1:0]   rdata;   // Registered read data

   modport target (output raddr, waddr, we, wstrb, wdata, input rdata);
   modport mem (input clk, raddr, waddr, we, wstrb, wdata, output rdata);

endinterface

`default_nettype wire

// ==== logic/sram8_inferred.sv ====
// Single-port RAM lane, 8 bits wide, with a registered read
// One copy is used per byte lane of the bus word
`timescale 1ns/100ps
`default_nettype none

module sram8_inferred #(
   parameter int abits = 9
) (
   input  logic              clk,
   input  logic [abits-1:0]  address,
   input  logic              we,
   input  logic [7:0]        wdata,
   output logic [7:0]        rdata
);

   localparam int DEPTH = 1 << abits;

   logic [7:0] ram [0:DEPTH-1];

   always_ff @(posedge clk) begin
      if (we) begin
         ram[address] <= wdata;
      end
      rdata <= ram[address];   // Old contents when writing the same location
   end

endmodule

`default_nettype wire

// ==== logic/srambytes_tech.sv ====
// Byte-lane SRAM that builds the bus data width from 8-bit RAM lanes
// Each lane takes its address from the entry of its alignment unit
`timescale 1ns/100ps
`default_nettype none

module srambytes_tech #(
   parameter int abits = 12
) (
   sram_port_if.mem port
);
   import sram_pkg::*;

   localparam int dw = CFG_LOG2_SYSBUS_DATA_BYTES;

   typedef logic [abits-dw-1:0] local_addr_type [0:CFG_SYSBUS_DATA_BYTES-1];

   local_addr_type                    address;
   logic [CFG_SYSBUS_DATA_BYTES-1:0]  wr_ena;

   for (genvar n = 0; n < CFG_SYSBUS_DATA_BYTES; n++) begin : rx

      assign wr_ena[n] = port.we & port.wstrb[n];

      // Lane address is the word part of waddr while writing and of raddr otherwise
      assign address[n] = port.we ? port.waddr[n / CFG_ALIGN_BYTES][abits-1:dw] :
                                    port.raddr[n / CFG_ALIGN_BYTES][abits-1:dw];

      sram8_inferred #(
         .abits (abits - dw)
      ) x0 (
         .clk     (port.clk),
         .address (address[n]),
         .we      (wr_ena[n]),
         .wdata   (port.wdata[8*n +: 8]),
         .rdata   (port.rdata[8*n +: 8])
      );

   end : rx

endmodule

`default_nettype wire

// ==== logic/req_queue.sv ====
// Circular request FIFO between the host side and the bus target
// Never overflows because the host only sends against granted credits
`timescale 1ns/100ps
`default_nettype none

module req_queue #(
   parameter int REQ_DEPTH = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   push,
   input  sram_pkg::sram_req_type push_req,
   input  logic                   pop,
   output sram_pkg::sram_req_type head,
   output logic                   not_empty
);
   import sram_pkg::*;

   localparam int PTR_BITS = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int CNT_BITS = $clog2(REQ_DEPTH + 1);

   sram_req_type          entries [0:REQ_DEPTH-1];
   logic [PTR_BITS-1:0]   wr_ptr;
   logic [PTR_BITS-1:0]   rd_ptr;
   logic [CNT_BITS-1:0]   count;

   // Pointers wrap at the depth, which need not be a power of two
   function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
      ptr_inc = (ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_req;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_BITS'(push) - CNT_BITS'(pop);   // Push and pop may coincide
      end
   end

   assign head      = entries[rd_ptr];
   assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== logic/sram_bus_target.sv ====
// Bus target with credit flow control in both directions
// Pops a request when a response credit is held, drives the memory port
// in that cycle and presents the response from the access stage one cycle later
`timescale 1ns/100ps
`default_nettype none

module sram_bus_target #(
   parameter int ADDR_BITS = 12,
   parameter int REQ_DEPTH = 4
) (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  sram_pkg::sram_req_type                     head,
   input  logic                                       not_empty,
   output logic                                       pop,
   output logic                                       req_credit,
   input  logic                                       rsp_credit,
   output logic                                       rsp_valid,
   output logic                                       rsp_write,
   output logic [sram_pkg::CFG_SYSBUS_DATA_BITS-1:0]  rsp_rdata,
   sram_port_if.target                                mem
);
   import sram_pkg::*;

   localparam int CNT_BITS     = $clog2(REQ_DEPTH + 1);
   localparam int RSP_CNT_BITS = 16;

   typedef enum logic {
      INIT_CREDITS,
      RUN
   } init_state_type;

   init_state_type                   init_state;
   logic [CNT_BITS-1:0]              init_cnt;    // Initial credits already sent
   logic [CNT_BITS-1:0]              pend_cnt;    // Pops still owed a credit
   logic                             ret_credit;
   logic [RSP_CNT_BITS-1:0]          rsp_cnt;     // Response slots granted by the host
   logic                             acc_valid;
   req_op_type                       acc_op;
   logic [CFG_SYSBUS_ADDR_BITS-1:0]  mem_addr;

   assign pop        = not_empty && (rsp_cnt != '0);
   assign ret_credit = pop || (pend_cnt != '0);   // Direct return or one from the backlog

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         init_state <= INIT_CREDITS;
         init_cnt   <= '0;
         pend_cnt   <= '0;
         req_credit <= 1'b0;
      end else begin
         case (init_state)
            INIT_CREDITS: begin
               req_credit <= 1'b1;
               init_cnt   <= init_cnt + 1'b1;
               pend_cnt   <= pend_cnt + CNT_BITS'(pop);   // Held back until the burst ends
               if (init_cnt == CNT_BITS'(REQ_DEPTH - 1)) begin
                  init_state <= RUN;
               end
            end
            RUN: begin
               req_credit <= ret_credit;
               pend_cnt   <= pend_cnt + CNT_BITS'(pop) - CNT_BITS'(ret_credit);
            end
            default: init_state <= RUN;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_cnt <= '0;
      end else begin
         rsp_cnt <= rsp_cnt + RSP_CNT_BITS'(rsp_credit) - RSP_CNT_BITS'(pop);
      end
   end

   // Both alignment units of the word share one address
   assign mem_addr = CFG_SYSBUS_ADDR_BITS'(head.addr[ADDR_BITS-1:0]);

   for (genvar i = 0; i < CFG_WORDS_ALIGNED; i++) begin : addr_gen
      assign mem.raddr[i] = mem_addr;
      assign mem.waddr[i] = mem_addr;
   end : addr_gen

   assign mem.we    = pop && (head.op == OP_WRITE);
   assign mem.wstrb = head.wstrb;
   assign mem.wdata = head.wdata;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc_valid <= 1'b0;
         acc_op    <= OP_READ;
      end else begin
         acc_valid <= pop;
         if (pop) begin
            acc_op <= head.op;
         end
      end
   end

   assign rsp_valid = acc_valid;
   assign rsp_write = (acc_op == OP_WRITE);
   assign rsp_rdata = mem.rdata;   // Lane registers hold the word read in the access cycle

endmodule

`default_nettype wire

// ==== logic/sram_subsystem.sv ====
// Top level of the SRAM target with plain host ports
// Connects the request queue, the bus target and the byte-lane memory
`timescale 1ns/100ps
`default_nettype none

module sram_subsystem #(
   parameter int ADDR_BITS = 12,
   parameter int REQ_DEPTH = 4
) (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        req_valid,
   input  logic                                        req_write,
   input  logic [ADDR_BITS-1:0]                        req_addr,
   input  logic [sram_pkg::CFG_SYSBUS_DATA_BYTES-1:0]  req_wstrb,
   input  logic [sram_pkg::CFG_SYSBUS_DATA_BITS-1:0]   req_wdata,
   output logic                                        req_credit,
   input  logic                                        rsp_credit,
   output logic                                        rsp_valid,
   output logic                                        rsp_write,
   output logic [sram_pkg::CFG_SYSBUS_DATA_BITS-1:0]   rsp_rdata
);
   import sram_pkg::*;

   sram_req_type  push_req;
   sram_req_type  head;
   logic          not_empty;
   logic          pop;

   assign push_req.op    = req_write ? OP_WRITE : OP_READ;
   assign push_req.addr  = CFG_SYSBUS_ADDR_BITS'(req_addr);
   assign push_req.wstrb = req_wstrb;
   assign push_req.wdata = req_wdata;

   sram_port_if port_if (.clk(clk));

   req_queue #(
      .REQ_DEPTH (REQ_DEPTH)
   ) u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (req_valid),
      .push_req  (push_req),
      .pop       (pop),
      .head      (head),
      .not_empty (not_empty)
   );

   sram_bus_target #(
      .ADDR_BITS (ADDR_BITS),
      .REQ_DEPTH (REQ_DEPTH)
   ) u_target (
      .clk        (clk),
      .rst_n      (rst_n),
      .head       (head),
      .not_empty  (not_empty),
      .pop        (pop),
      .req_credit (req_credit),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp_write  (rsp_write),
      .rsp_rdata  (rsp_rdata),
      .mem        (port_if.target)
   );

   srambytes_tech #(
      .abits (ADDR_BITS)
   ) u_mem (
      .port (port_if.mem)
   );

endmodule

`default_nettype wire

// ==== dv/sram_ref_model.svh ====
// Reference model of the SRAM target, included inside the testbench module
// Holds the written bytes and queues the expected response of every request
`ifndef SRAM_REF_MODEL_SVH
`define SRAM_REF_MODEL_SVH

logic [7:0]   model_mem [0:MEM_BYTES-1];
bit           model_valid [0:MEM_BYTES-1];   // Set once a byte has been written
bit           exp_write_q [$];
logic [63:0]  exp_data_q [$];
logic [63:0]  exp_mask_q [$];                // Only written bytes are compared

// Merges a strobed write into the model and expects an acknowledge
function automatic void store_write(input int word, input logic [7:0] strb,
                                    input logic [63:0] data);
   logic [ADDR_BITS-1:0]  idx;
   logic [7:0]            bits;
   logic [63:0]           val;
   bits = strb;
   val  = data;
   for (int i = 0; i < 8; i++) begin
      idx = ADDR_BITS'(word * 8 + i);
      if (bits[0]) begin
         model_mem[idx]   = val[7:0];
         model_valid[idx] = 1'b1;
      end
      bits = bits >> 1;
      val  = val >> 8;
   end
   exp_write_q.push_back(1'b1);
   exp_data_q.push_back('0);
   exp_mask_q.push_back('0);
endfunction

// Expects the word as the model holds it when the read is sent
function automatic void expect_read(input int word);
   logic [ADDR_BITS-1:0]  idx;
   logic [63:0]           data;
   logic [63:0]           mask;
   for (int i = 7; i >= 0; i--) begin
      idx  = ADDR_BITS'(word * 8 + i);
      data = {data[55:0], model_mem[idx]};   // Byte 0 ends up in the low lane
      mask = {mask[55:0], model_valid[idx] ? 8'hff : 8'h00};
   end
   exp_write_q.push_back(1'b0);
   exp_data_q.push_back(data);
   exp_mask_q.push_back(mask);
endfunction

`endif

// ==== dv/sram_tb.sv ====
// Testbench for the SRAM target with a random host that counts credits
// Responses are checked in order against the included reference model
`timescale 1ns/100ps
`default_nettype none

module sram_tb;
   import sram_pkg::*;

   localparam int ADDR_BITS = 12;
   localparam int REQ_DEPTH = 4;
   localparam int MEM_BYTES = 1 << ADDR_BITS;
   localparam int WORDS     = MEM_BYTES / CFG_SYSBUS_DATA_BYTES;
   localparam int LIMIT     = 200;   // Longest any single wait may take in cycles

   logic         clk = 1'b0;
   logic         rst_n;
   logic         req_valid;
   logic         req_write;
   logic [ADDR_BITS-1:0] req_addr;
   logic [7:0]   req_wstrb;
   logic [63:0]  req_wdata;
   logic         req_credit;
   logic         rsp_credit;
   logic         rsp_valid;
   logic         rsp_write;
   logic [63:0]  rsp_rdata;

   int errors = 0;
   int req_credits = 0;     // Request credits the host holds
   int credit_pulses = 0;
   int rsp_seen = 0;
   int grants_open = 0;     // Response credits granted and not yet used
   int grant_pct = 0;       // Chance per cycle of a response credit grant
   int sent = 0;

   `include "sram_ref_model.svh"

   sram_subsystem #(
      .ADDR_BITS (ADDR_BITS),
      .REQ_DEPTH (REQ_DEPTH)
   ) DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_write  (req_write),
      .req_addr   (req_addr),
      .req_wstrb  (req_wstrb),
      .req_wdata  (req_wdata),
      .req_credit (req_credit),
      .rsp_credit (rsp_credit),
      .rsp_valid  (rsp_valid),
      .rsp_write  (rsp_write),
      .rsp_rdata  (rsp_rdata)
   );

   always #2 clk = ~clk;

   task automatic report_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
   endtask

   task automatic report_problem(input string what);
      errors++;
      $display("Error: %s", what);
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("Test %0d %s: ok", num, name);
      end else begin
         $display("Test %0d %s: %0d errors", num, name, errors - errs_before);
      end
   endtask

   // DUT outputs are sampled at the falling edge, half a cycle after they change
   always @(negedge clk) begin : monitor
      bit           exp_w;
      logic [63:0]  exp_d;
      logic [63:0]  exp_m;
      if (!rst_n && req_credit !== 1'b0) report_value("req_credit", 64'(req_credit), 64'(0));
      if (!rst_n && rsp_valid !== 1'b0) report_value("rsp_valid", 64'(rsp_valid), 64'(0));
      if (rst_n && req_credit === 1'b1) begin
         req_credits++;
         credit_pulses++;
      end
      if (rst_n && rsp_valid === 1'b1) begin
         rsp_seen++;
         if (exp_write_q.size() == 0) begin
            report_problem("a response arrived with no request outstanding");
         end else begin
            exp_w = exp_write_q.pop_front();
            exp_d = exp_data_q.pop_front();
            exp_m = exp_mask_q.pop_front();
            if (grants_open > 0) begin
               grants_open--;
            end else begin
               report_problem("a response arrived without a response credit");
            end
            if (rsp_write !== exp_w) report_value("rsp_write", 64'(rsp_write), 64'(exp_w));
            if (!exp_w && (rsp_rdata & exp_m) !== (exp_d & exp_m)) begin
               report_value("rsp_rdata", rsp_rdata & exp_m, exp_d & exp_m);
            end
         end
      end
   end

   // Advances one cycle and may grant a response credit for a pending request
   task automatic next_cycle();
      @(posedge clk);
      #1;
      req_valid  = 1'b0;
      rsp_credit = 1'b0;
      if (grants_open < exp_write_q.size() && $urandom_range(0, 99) < grant_pct) begin
         rsp_credit = 1'b1;
         grants_open++;
      end
   endtask

   task automatic send_request(input bit write, input int word, input logic [7:0] strb,
                               input logic [63:0] data);
      int waited;
      waited = 0;
      next_cycle();
      while (req_credits == 0 && waited < LIMIT) begin
         next_cycle();
         waited++;
      end
      if (req_credits == 0) begin
         report_problem("timed out waiting for a request credit");
      end else begin
         req_valid = 1'b1;
         req_write = write;
         req_addr  = ADDR_BITS'(word * CFG_SYSBUS_DATA_BYTES);
         req_wstrb = strb;
         req_wdata = data;
         req_credits--;
         sent++;
         if (write) store_write(word, strb, data);
         else expect_read(word);
      end
   endtask

   // Waits for all responses and for the host to hold every request credit again
   task automatic drain_responses();
      int waited;
      waited = 0;
      while ((exp_write_q.size() != 0 || req_credits != REQ_DEPTH) && waited < LIMIT) begin
         next_cycle();
         waited++;
      end
      if (exp_write_q.size() != 0) report_problem("timed out waiting for responses");
      if (req_credits != REQ_DEPTH) report_problem("request credits did not all return");
   endtask

   initial begin : main
      int test_errs;
      int base;
      int word;
      int seen;
      int pulses;
      int sent0;
      int waited;
      void'($urandom(32'hb367_77ac));
      rst_n      = 1'b0;
      req_valid  = 1'b0;
      req_write  = 1'b0;
      req_addr   = '0;
      req_wstrb  = '0;
      req_wdata  = '0;
      rsp_credit = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;

      test_errs = errors;
      repeat (REQ_DEPTH + 8) next_cycle();
      if (credit_pulses != REQ_DEPTH) begin
         report_value("req_credit pulses", 64'(credit_pulses), 64'(REQ_DEPTH));
      end
      send_request(1'b0, 0, 8'h00, '0);   // Stays queued while no response credit is granted
      repeat (8) next_cycle();
      if (rsp_seen != 0) report_value("rsp_valid pulses", 64'(rsp_seen), 64'(0));
      report_test(1, "initial credits", test_errs);

      test_errs = errors;
      grant_pct = 100;
      base = $urandom_range(0, WORDS - 32);
      for (int k = 0; k < 16; k++) send_request(1'b1, base + k, 8'hff, {$urandom(), $urandom()});
      for (int k = 0; k < 16; k++) send_request(1'b0, base + k, 8'h00, '0);
      drain_responses();
      report_test(2, "full writes and reads", test_errs);

      test_errs = errors;
      grant_pct = 60;
      for (int k = 0; k < 48; k++) begin
         word = base + $urandom_range(0, 7);
         if ($urandom_range(0, 2) == 0) send_request(1'b0, word, 8'h00, '0);
         else send_request(1'b1, word, 8'($urandom()), {$urandom(), $urandom()});
      end
      for (int k = 0; k < 8; k++) send_request(1'b0, base + k, 8'h00, '0);
      drain_responses();
      report_test(3, "byte strobes", test_errs);

      test_errs = errors;
      grant_pct = 0;
      seen = rsp_seen;
      for (int k = 0; k < REQ_DEPTH; k++) begin
         if (k < REQ_DEPTH / 2) send_request(1'b1, base + 20 + k, 8'hff, {$urandom(), $urandom()});
         else send_request(1'b0, base + 20 + k - REQ_DEPTH / 2, 8'h00, '0);
      end
      repeat (20) next_cycle();
      if (req_credits != 0) report_value("request credits held", 64'(req_credits), 64'(0));
      if (rsp_seen != seen) report_value("rsp_valid count", 64'(rsp_seen), 64'(seen));
      for (int k = 1; k <= REQ_DEPTH; k++) begin
         next_cycle();
         rsp_credit = 1'b1;   // Each grant releases one response
         grants_open++;
         waited = 0;
         while (rsp_seen < seen + k && waited < 10) begin
            next_cycle();
            waited++;
         end
         repeat (4) next_cycle();
         if (rsp_seen != seen + k) report_value("rsp_valid count", 64'(rsp_seen), 64'(seen + k));
      end
      grant_pct = 50;
      drain_responses();
      report_test(4, "response back-pressure", test_errs);

      test_errs = errors;
      grant_pct = 40;
      pulses = credit_pulses;
      sent0 = sent;
      for (int k = 0; k < 300; k++) begin
         word = base + $urandom_range(0, 31);
         if ($urandom_range(0, 1) == 1) begin
            send_request(1'b1, word, 8'($urandom()), {$urandom(), $urandom()});
         end else begin
            send_request(1'b0, word, 8'h00, '0);
         end
         if ($urandom_range(0, 3) == 0) next_cycle();   // Idle gap on the request side
      end
      drain_responses();
      if (credit_pulses - pulses != sent - sent0) begin
         report_value("req_credit returns", 64'(credit_pulses - pulses), 64'(sent - sent0));
      end
      report_test(5, "random traffic", test_errs);

      $display("Summary: 5 tests, %0d requests, %0d responses, %0d errors", sent, rsp_seen, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+dv
logic/sram_pkg.sv
logic/sram_port_if.sv
logic/sram8_inferred.sv
logic/srambytes_tech.sv
logic/req_queue.sv
logic/sram_bus_target.sv
logic/sram_subsystem.sv
dv/sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SRAM target testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module sram_tb -o sram_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sram_tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
   exit 0
fi
exit 1
